//--- all.f
armPkg.sv
ctrlBus.sv
alu.sv
regFile.sv
programCounter.sv
condUnit.sv
mainFsm.sv
datapath.sv
armMulticycle.sv
tbArm.sv

//--- alu.sv
// ALU for add, subtract, and, or with NZCV flag generation
`timescale 1ns/1ns
`default_nettype none

module alu import armPkg::*; (
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  aluOp_t            op,
    output logic [DATA_W-1:0] result,
    output logic [3:0]        flags
);

    logic              isSub;
    logic              isArith;
    logic [DATA_W-1:0] bIn;
    logic [DATA_W:0]   sum;

    // Subtract is a + ~b + 1, so the carry out is the ARM no-borrow bit
    assign isSub   = (op == ALU_SUB);
    assign isArith = (op == ALU_ADD) || isSub;
    assign bIn     = isSub ? ~b : b;
    assign sum     = {1'b0, a} + {1'b0, bIn} + {{DATA_W{1'b0}}, isSub};

    always_comb begin
        case (op)
            ALU_AND: result = a & b;
            ALU_ORR: result = a | b;
            default: result = sum[DATA_W-1:0];
        endcase
    end

    // Flag order is N Z C V from the top bit down
    assign flags[3] = result[DATA_W-1];
    assign flags[2] = (result == '0);
    assign flags[1] = isArith & sum[DATA_W];
    // Overflow when both adder inputs agree in sign and the result does not
    assign flags[0] = isArith & (a[DATA_W-1] == bIn[DATA_W-1])
                    & (result[DATA_W-1] != a[DATA_W-1]);

endmodule

`default_nettype wire

//--- armMulticycle.sv
// Processor top level joining the state machine, condition unit and datapath
`timescale 1ns/1ns
`default_nettype none

module armMulticycle import armPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] readData,
    output logic [DATA_W-1:0] adr,
    output logic [DATA_W-1:0] writeData,
    output logic              memWrite
);

    logic [DATA_W-1:0] instr;
    logic [3:0]        aluFlags;
    logic              regReq;
    logic              memReq;
    logic              brReq;
    logic              flagReq;

    ctrlBus ctrl ();

    // Requests leave the FSM ungated and pass through the condition unit
    mainFsm uFsm (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        .bus     (ctrl.fsm),
        .regReq  (regReq),
        .memReq  (memReq),
        .brReq   (brReq),
        .flagReq (flagReq)
    );

    condUnit uCond (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .aluFlags (aluFlags),
        .regReq   (regReq),
        .memReq   (memReq),
        .brReq    (brReq),
        .flagReq  (flagReq),
        .bus      (ctrl.cond),
        .memWrite (memWrite)
    );

    datapath uDp (
        .clk       (clk),
        .reset     (reset),
        .readData  (readData),
        .bus       (ctrl.dp),
        .instr     (instr),
        .aluFlags  (aluFlags),
        .adr       (adr),
        .writeData (writeData)
    );

endmodule

`default_nettype wire

//--- armPkg.sv
// Word and register widths, instruction field positions, enums and decode constants
`default_nettype none

package armPkg;

    // -------------------------------------------------------------------------
    // Widths and fixed register numbers
    // -------------------------------------------------------------------------
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 4;

    // R15 is not stored in the register file, it is built from the PC
    localparam logic [REG_ADDR_W-1:0] PC_REG  = 4'd15;
    localparam logic [DATA_W-1:0]     PC_STEP = 32'd4;

    // -------------------------------------------------------------------------
    // Instruction field positions
    // -------------------------------------------------------------------------
    localparam int COND_LSB = 28;
    localparam int OP_LSB   = 26;
    localparam int I_BIT    = 25;
    localparam int CMD_LSB  = 21;
    // S and L share bit 20, the class decides which meaning applies
    localparam int S_BIT    = 20;
    localparam int L_BIT    = 20;
    localparam int RN_LSB   = 16;
    localparam int RD_LSB   = 12;
    localparam int ROT_LSB  = 8;

    // Data-processing command field values
    localparam logic [3:0] CMD_AND = 4'b0000;
    localparam logic [3:0] CMD_SUB = 4'b0010;
    localparam logic [3:0] CMD_ADD = 4'b0100;
    localparam logic [3:0] CMD_CMP = 4'b1010;
    localparam logic [3:0] CMD_ORR = 4'b1100;

    // Instruction classes taken from bits 27:26
    localparam logic [1:0] OP_DP  = 2'b00;
    localparam logic [1:0] OP_MEM = 2'b01;
    localparam logic [1:0] OP_BR  = 2'b10;

    // Operand and writeback selections in the datapath
    localparam logic SRCB_REG   = 1'b0;
    localparam logic SRCB_IMM   = 1'b1;
    localparam logic RES_ALUOUT = 1'b0;
    localparam logic RES_DATA   = 1'b1;

    // -------------------------------------------------------------------------
    // Enumerated types
    // -------------------------------------------------------------------------
    typedef enum logic [3:0] {
        FETCH, DECODE, MEMADR, MEMRD, MEMWB, MEMWRITE,
        EXECR, EXECI, ALUWB, ALUNOWB, BRANCH
    } fsmState_t;

    typedef enum logic [1:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR
    } aluOp_t;

    // Code 4'b1111 has no name here and is treated like AL
    typedef enum logic [3:0] {
        EQ, NE, CS, CC, MI, PL, VS, VC, HI, LS, GE, LT, GT, LE, AL
    } cond_t;

endpackage

`default_nettype wire

//--- condUnit.sv
// NZCV flag register, condition evaluation and write-enable gating
`timescale 1ns/1ns
`default_nettype none

module condUnit import armPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] instr,
    input  logic [3:0]        aluFlags,
    input  logic              regReq,
    input  logic              memReq,
    input  logic              brReq,
    input  logic              flagReq,
    ctrlBus.cond              bus,
    output logic              memWrite
);

    logic [3:0] flags;
    logic       n;
    logic       z;
    logic       c;
    logic       v;
    logic       ge;
    logic       condPass;
    logic       condHeld;
    logic       isArith;
    logic [3:0] cmd;
    cond_t      cond;

    assign {n, z, c, v} = flags;
    assign ge   = (n == v);
    assign cond = cond_t'(instr[COND_LSB +: 4]);
    assign cmd  = instr[CMD_LSB +: 4];

    // Logic operations leave C and V alone
    assign isArith = (cmd == CMD_ADD) || (cmd == CMD_SUB) || (cmd == CMD_CMP);

    // -------------------------------------------------------------------------
    // Condition check against the stored flags
    // -------------------------------------------------------------------------
    always_comb begin
        case (cond)
            EQ: condPass = z;
            NE: condPass = ~z;
            CS: condPass = c;
            CC: condPass = ~c;
            MI: condPass = n;
            PL: condPass = ~n;
            VS: condPass = v;
            VC: condPass = ~v;
            HI: condPass = c & ~z;
            LS: condPass = ~c | z;
            GE: condPass = ge;
            LT: condPass = ~ge;
            GT: condPass = ~z & ge;
            LE: condPass = z | ~ge;
            default: condPass = 1'b1;
        endcase
    end

    // A failed instruction keeps its cycles but every write is masked
    // Register writes come one state after execute when the flags may already hold
    // this instruction's result, so they use the condition held from the state before
    assign bus.regWrite = regReq & condHeld;
    assign bus.pcBranch = brReq & condPass;
    assign memWrite     = memReq & condPass;

    // Flags change at the end of the execute state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags    <= '0;
            condHeld <= 1'b0;
        end else begin
            condHeld <= condPass;
            if (flagReq && condPass) begin
                flags[3:2] <= aluFlags[3:2];
                if (isArith) begin
                    flags[1:0] <= aluFlags[1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- ctrlBus.sv
// Control bus between the state machine, the condition unit and the datapath
`timescale 1ns/1ns
`default_nettype none

interface ctrlBus import armPkg::*; ();

    // Levels from the state machine, valid for the current state only
    logic       irWrite;
    logic       adrSrc;
    logic       srcBSel;
    logic       resultSrc;
    aluOp_t     aluOp;
    logic       abWrite;
    logic       pcStep;
    logic [1:0] immClass;

    // Enables after the condition check
    logic       regWrite;
    logic       pcBranch;

    modport fsm (
        output irWrite, adrSrc, srcBSel, resultSrc, aluOp, abWrite, pcStep, immClass
    );

    modport cond (
        output regWrite, pcBranch
    );

    // The datapath only listens
    modport dp (
        input irWrite, adrSrc, srcBSel, resultSrc, aluOp, abWrite, pcStep, immClass,
        input regWrite, pcBranch
    );

endinterface

`default_nettype wire

//--- datapath.sv
// Datapath with IR, data, A, B and result registers, extension and muxes
`timescale 1ns/1ns
`default_nettype none

module datapath import armPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] readData,
    ctrlBus.dp                bus,
    output logic [DATA_W-1:0] instr,
    output logic [3:0]        aluFlags,
    output logic [DATA_W-1:0] adr,
    output logic [DATA_W-1:0] writeData
);

    logic [DATA_W-1:0]     pc;
    logic [DATA_W-1:0]     pcPlus8;
    logic [DATA_W-1:0]     dataReg;
    logic [DATA_W-1:0]     aReg;
    logic [DATA_W-1:0]     bReg;
    logic [DATA_W-1:0]     rd1;
    logic [DATA_W-1:0]     rd2;
    logic [DATA_W-1:0]     extImm;
    logic [DATA_W-1:0]     srcB;
    logic [DATA_W-1:0]     aluResult;
    logic [DATA_W-1:0]     aluOut;
    logic [DATA_W-1:0]     result;
    logic [2*DATA_W-1:0]   immRot;
    logic [REG_ADDR_W-1:0] ra2;

    // -------------------------------------------------------------------------
    // Pipeline-free holding registers between states
    // -------------------------------------------------------------------------
    // The IR feeds all decode, so it starts from a known word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr <= '0;
        end else if (bus.irWrite) begin
            instr <= readData;
        end
    end

    // Data and ALU result registers sample every cycle; A and B only in DECODE
    always_ff @(posedge clk) begin
        dataReg <= readData;
        aluOut  <= aluResult;
        if (bus.abWrite) begin
            aReg <= rd1;
            bReg <= rd2;
        end
    end

    // -------------------------------------------------------------------------
    // PC, register file and immediate extension
    // -------------------------------------------------------------------------
    programCounter uPc (
        .clk          (clk),
        .reset        (reset),
        .pcStep       (bus.pcStep),
        .pcBranch     (bus.pcBranch),
        .branchOffset (extImm),
        .pc           (pc),
        .pcPlus8      (pcPlus8)
    );

    // Stores read Rd on the second port, everything else reads Rm
    assign ra2 = (bus.immClass == OP_MEM) ? instr[RD_LSB +: REG_ADDR_W]
                                          : instr[REG_ADDR_W-1:0];

    regFile uRegs (
        .clk (clk),
        .we  (bus.regWrite),
        .ra1 (instr[RN_LSB +: REG_ADDR_W]),
        .ra2 (ra2),
        .wa  (instr[RD_LSB +: REG_ADDR_W]),
        .wd  (result),
        .r15 (pcPlus8),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    // Rotate right by twice the rot field, done as a shift of a doubled word
    assign immRot = {2{{(DATA_W-8){1'b0}}, instr[7:0]}} >> {instr[ROT_LSB +: 4], 1'b0};

    always_comb begin
        case (bus.immClass)
            OP_DP:   extImm = immRot[DATA_W-1:0];
            OP_MEM:  extImm = {{(DATA_W-12){1'b0}}, instr[11:0]};
            // Branch word offset becomes a byte offset
            default: extImm = {{(DATA_W-26){instr[23]}}, instr[23:0], 2'b00};
        endcase
    end

    // -------------------------------------------------------------------------
    // ALU and output muxes
    // -------------------------------------------------------------------------
    assign srcB = (bus.srcBSel == SRCB_IMM) ? extImm : bReg;

    alu uAlu (
        .a      (aReg),
        .b      (srcB),
        .op     (bus.aluOp),
        .result (aluResult),
        .flags  (aluFlags)
    );

    assign result    = (bus.resultSrc == RES_DATA) ? dataReg : aluOut;
    assign adr       = bus.adrSrc ? aluOut : pc;
    assign writeData = bReg;

endmodule

`default_nettype wire

//--- mainFsm.sv
// Instruction-class decode and multicycle control state machine
`timescale 1ns/1ns
`default_nettype none

module mainFsm import armPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] instr,
    ctrlBus.fsm               bus,
    output logic              regReq,
    output logic              memReq,
    output logic              brReq,
    output logic              flagReq
);

    fsmState_t  state;
    fsmState_t  nextState;
    logic [1:0] opClass;
    logic [3:0] cmd;
    logic       immBit;
    logic       loadBit;
    logic       setFlags;
    logic       isCmp;
    aluOp_t     dpOp;

    // -------------------------------------------------------------------------
    // Field decode of the latched instruction
    // -------------------------------------------------------------------------
    assign opClass  = instr[OP_LSB +: 2];
    assign cmd      = instr[CMD_LSB +: 4];
    assign immBit   = instr[I_BIT];
    assign loadBit  = instr[L_BIT];
    assign setFlags = instr[S_BIT];
    assign isCmp    = (cmd == CMD_CMP);

    // CMP is a subtract whose result is thrown away
    always_comb begin
        case (cmd)
            CMD_AND: dpOp = ALU_AND;
            CMD_SUB: dpOp = ALU_SUB;
            CMD_CMP: dpOp = ALU_SUB;
            CMD_ORR: dpOp = ALU_ORR;
            default: dpOp = ALU_ADD;
        endcase
    end

    // The extender in the datapath picks its format from the class directly
    assign bus.immClass = opClass;

    // -------------------------------------------------------------------------
    // State register and sequencing
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = FETCH;
        case (state)
            FETCH: nextState = DECODE;
            DECODE: begin
                case (opClass)
                    OP_DP:   nextState = immBit ? EXECI : EXECR;
                    OP_MEM:  nextState = MEMADR;
                    OP_BR:   nextState = BRANCH;
                    default: nextState = FETCH;
                endcase
            end
            // CMP skips the register writeback
            EXECR: nextState = isCmp ? ALUNOWB : ALUWB;
            EXECI: nextState = isCmp ? ALUNOWB : ALUWB;
            MEMADR: nextState = loadBit ? MEMRD : MEMWRITE;
            MEMRD: nextState = MEMWB;
            default: nextState = FETCH;
        endcase
    end

    // -------------------------------------------------------------------------
    // Control levels per state
    // -------------------------------------------------------------------------
    always_comb begin
        bus.irWrite   = 1'b0;
        bus.adrSrc    = 1'b0;
        bus.srcBSel   = SRCB_REG;
        bus.resultSrc = RES_ALUOUT;
        bus.aluOp     = ALU_ADD;
        bus.abWrite   = 1'b0;
        bus.pcStep    = 1'b0;
        regReq        = 1'b0;
        memReq        = 1'b0;
        brReq         = 1'b0;
        flagReq       = 1'b0;
        case (state)
            // Address comes from the PC, instruction and PC update together
            FETCH: begin
                bus.irWrite = 1'b1;
                bus.pcStep  = 1'b1;
            end
            DECODE: bus.abWrite = 1'b1;
            // Base plus unsigned offset goes into the result register
            MEMADR: bus.srcBSel = SRCB_IMM;
            MEMRD: begin
                bus.adrSrc  = 1'b1;
                bus.srcBSel = SRCB_IMM;
            end
            MEMWB: begin
                bus.resultSrc = RES_DATA;
                regReq        = 1'b1;
            end
            MEMWRITE: begin
                bus.adrSrc = 1'b1;
                memReq     = 1'b1;
            end
            EXECR: begin
                bus.aluOp = dpOp;
                flagReq   = setFlags | isCmp;
            end
            EXECI: begin
                bus.aluOp   = dpOp;
                bus.srcBSel = SRCB_IMM;
                flagReq     = setFlags | isCmp;
            end
            ALUWB: regReq = 1'b1;
            BRANCH: brReq = 1'b1;
            // ALUNOWB only spends the cycle
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- programCounter.sv
// Program counter with fetch step, branch load and the R15 read value
`timescale 1ns/1ns
`default_nettype none

module programCounter import armPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              pcStep,
    input  logic              pcBranch,
    input  logic [DATA_W-1:0] branchOffset,
    output logic [DATA_W-1:0] pc,
    output logic [DATA_W-1:0] pcPlus8
);

    // After FETCH the PC already points one word past the instruction,
    // so one more step gives the architectural R15 value
    assign pcPlus8 = pc + PC_STEP;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (pcBranch) begin
            // Target is instruction address + 8 + offset
            pc <= pcPlus8 + branchOffset;
        end else if (pcStep) begin
            pc <= pc + PC_STEP;
        end
    end

endmodule

`default_nettype wire

//--- regFile.sv
// Register file of R0 to R14 with the R15 read path
`timescale 1ns/1ns
`default_nettype none

module regFile import armPkg::*; (
    input  logic                  clk,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] ra1,
    input  logic [REG_ADDR_W-1:0] ra2,
    input  logic [REG_ADDR_W-1:0] wa,
    input  logic [DATA_W-1:0]     wd,
    input  logic [DATA_W-1:0]     r15,
    output logic [DATA_W-1:0]     rd1,
    output logic [DATA_W-1:0]     rd2
);

    logic [DATA_W-1:0] regs [0:PC_REG-1];

    // A write aimed at R15 is dropped since the PC owns that register
    always_ff @(posedge clk) begin
        if (we && (wa != PC_REG)) begin
            regs[wa] <= wd;
        end
    end

    // Both read ports are combinational
    assign rd1 = (ra1 == PC_REG) ? r15 : regs[ra1];
    assign rd2 = (ra2 == PC_REG) ? r15 : regs[ra2];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/bash
# Build the ARM multicycle testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f all.f --top-module tbArm
output=$(./obj_dir/VtbArm)
echo "$output"
if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi

//--- tbArm.sv
// Testbench with clock, reset, memory model, instruction encoders, directed tests and checks
`timescale 1ns/1ns
`default_nettype none

module tbArm import armPkg::*; ();

    localparam int MEM_WORDS    = 256;
    localparam int LOG_DEPTH    = 64;
    localparam int RESET_CYCLES = 8;
    // Five programs of about 30 instructions at 5 cycles each plus margin
    localparam int CYCLE_LIMIT  = 2000;
    localparam int SEED         = 19764;
    localparam int SENTINEL_ADR = 'h3FC;
    localparam int LOOP_COUNT   = 5;

    logic              clk = 1'b0;
    logic              reset = 1'b1;
    logic              loadImage = 1'b0;
    logic [DATA_W-1:0] readData;
    logic [DATA_W-1:0] adr;
    logic [DATA_W-1:0] writeData;
    logic              memWrite;

    logic [DATA_W-1:0] mem     [0:MEM_WORDS-1];
    logic [DATA_W-1:0] image   [0:MEM_WORDS-1];
    logic [DATA_W-1:0] logAddr [0:LOG_DEPTH-1];
    logic [DATA_W-1:0] logData [0:LOG_DEPTH-1];
    logic [DATA_W-1:0] expAddr [$];
    logic [DATA_W-1:0] expData [$];
    int                logCount;
    int                progIdx;
    int                errors;
    int                checks;
    int                cycleCount;

    armMulticycle u_dut (
        .clk       (clk),
        .reset     (reset),
        .readData  (readData),
        .adr       (adr),
        .writeData (writeData),
        .memWrite  (memWrite)
    );

    always #20 clk = ~clk;

    // -------------------------------------------------------------------------
    // Memory model with store log
    // -------------------------------------------------------------------------
    // Word-addressed memory with combinational reads
    assign readData = mem[adr[9:2]];

    // The whole program image is copied in one edge while the core sits in reset
    always @(posedge clk) begin : memoryPort
        int i;
        if (loadImage) begin
            for (i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= image[i];
            end
            logCount <= 0;
        end else if (memWrite) begin
            mem[adr[9:2]] <= writeData;
            if (logCount < LOG_DEPTH) begin
                logAddr[logCount] <= adr;
                logData[logCount] <= writeData;
                logCount <= logCount + 1;
            end
        end
    end

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // -------------------------------------------------------------------------
    // Instruction encoders
    // -------------------------------------------------------------------------
    // Data processing with a rotated 8-bit immediate and operands in Rd then Rn order
    function automatic logic [31:0] dpImm(logic [3:0] cond, logic [3:0] cmd, int s,
                                          int rd, int rn, int rot, int imm8);
        return {cond, 2'b00, 1'b1, cmd, s[0], rn[3:0], rd[3:0], rot[3:0], imm8[7:0]};
    endfunction

    function automatic logic [31:0] dpReg(logic [3:0] cond, logic [3:0] cmd, int s,
                                          int rd, int rn, int rm);
        return {cond, 2'b00, 1'b0, cmd, s[0], rn[3:0], rd[3:0], 8'h00, rm[3:0]};
    endfunction

    // Pre-indexed form that adds the offset and skips base writeback
    function automatic logic [31:0] memOp(logic [3:0] cond, int load, int rd, int rn,
                                          int offset);
        return {cond, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load[0], rn[3:0], rd[3:0],
                offset[11:0]};
    endfunction

    function automatic logic [31:0] branch(logic [3:0] cond, int wordOffset);
        return {cond, 4'b1010, wordOffset[23:0]};
    endfunction

    // Immediate operand value as imm8 rotated right by twice rot
    function automatic logic [31:0] rotImm(int imm8, int rot);
        logic [31:0] v;
        v = {24'h0, imm8[7:0]};
        return (v >> (2 * rot)) | (v << (32 - 2 * rot));
    endfunction

    // -------------------------------------------------------------------------
    // Checks
    // -------------------------------------------------------------------------
    task automatic checkWord(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkTrue(bit ok, string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("t=%0t %s", $time, what);
        end
    endtask

    // -------------------------------------------------------------------------
    // Program building and running
    // -------------------------------------------------------------------------
    task automatic emit(logic [31:0] word);
        image[progIdx] = word;
        progIdx++;
    endtask

    // Every program starts by clearing R0, which then serves as the zero base
    task automatic startProgram();
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            image[i] = 32'hBAD0_0000 | i;
        end
        progIdx = 0;
        expAddr.delete();
        expData.delete();
        emit(dpImm(AL, CMD_AND, 0, 0, 0, 0, 0));
    endtask

    // STR Rd,[R0,#offset] that is expected to land
    task automatic storeExpect(int rd, int offset, logic [31:0] value);
        emit(memOp(AL, 0, rd, 0, offset));
        expAddr.push_back(offset);
        expData.push_back(value);
    endtask

    task automatic condStore(logic [3:0] cond, int rd, int offset, logic [31:0] value,
                             bit taken);
        emit(memOp(cond, 0, rd, 0, offset));
        if (taken) begin
            expAddr.push_back(offset);
            expData.push_back(value);
        end
    endtask

    // Sentinel store ends the program and the core then spins on a branch to itself
    task automatic finishProgram();
        storeExpect(0, SENTINEL_ADR, 32'd0);
        emit(branch(AL, -2));
    endtask

    task automatic applyReset();
        int i;
        @(posedge clk);
        reset     <= 1'b1;
        loadImage <= 1'b1;
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            loadImage <= 1'b0;
            checkWord("memWrite", 32'd0, {31'd0, memWrite});
        end
        reset <= 1'b0;
        // First edge out of reset is the first fetch
        @(posedge clk);
        checkWord("memWrite", 32'd0, {31'd0, memWrite});
        checkWord("adr", 32'd0, adr);
    endtask

    task automatic runProgram();
        while (!(logCount > 0 && logAddr[logCount-1] == SENTINEL_ADR)) begin
            @(posedge clk);
        end
    endtask

    task automatic compareStores(string testName);
        int i;
        for (i = 0; i < expAddr.size(); i++) begin
            checkTrue(i < logCount,
                      $sformatf("%s: store to %h never happened", testName, expAddr[i]));
            if (i < logCount) begin
                checkWord("adr", expAddr[i], logAddr[i]);
                checkWord("writeData", expData[i], logData[i]);
            end
        end
        checkTrue(logCount <= expAddr.size(),
                  $sformatf("%s: %0d stores seen but only %0d expected", testName,
                            logCount, expAddr.size()));
    endtask

    // -------------------------------------------------------------------------
    // Directed tests
    // -------------------------------------------------------------------------
    task automatic dataProcessingTest();
        logic [31:0] val [1:9];
        int i;
        startProgram();
        val[1] = 32'd200;
        val[2] = rotImm('h3F, 4);
        val[3] = val[1] - 32'h17;
        val[4] = val[1] + val[2];
        val[5] = val[2] - val[1];
        val[6] = val[4] & 32'hF0;
        val[7] = val[1] | rotImm('hAB, 1);
        val[8] = val[3] | val[2];
        val[9] = val[4] & val[5];
        emit(dpImm(AL, CMD_ADD, 0, 1, 0, 0, 200));
        emit(dpImm(AL, CMD_ADD, 0, 2, 0, 4, 'h3F));
        emit(dpImm(AL, CMD_SUB, 0, 3, 1, 0, 'h17));
        emit(dpReg(AL, CMD_ADD, 0, 4, 1, 2));
        emit(dpReg(AL, CMD_SUB, 0, 5, 2, 1));
        emit(dpImm(AL, CMD_AND, 0, 6, 4, 0, 'hF0));
        emit(dpImm(AL, CMD_ORR, 0, 7, 1, 1, 'hAB));
        emit(dpReg(AL, CMD_ORR, 0, 8, 3, 2));
        emit(dpReg(AL, CMD_AND, 0, 9, 4, 5));
        for (i = 1; i <= 9; i++) begin
            storeExpect(i, 'h100 + 4 * i, val[i]);
        end
        finishProgram();
        applyReset();
        runProgram();
        compareStores("data processing");
    endtask

    task automatic loadStoreTest();
        startProgram();
        image['h80] = 32'hCAFE_F00D;
        image['h81] = 32'h1234_5678;
        emit(memOp(AL, 1, 1, 0, 'h200));
        storeExpect(1, 'h240, 32'hCAFE_F00D);
        // Base register 0x200 is built as 0x02 rotated right by 24
        emit(dpImm(AL, CMD_ADD, 0, 3, 0, 12, 'h02));
        emit(memOp(AL, 1, 4, 3, 4));
        emit(memOp(AL, 0, 4, 3, 'h50));
        expAddr.push_back(32'h250);
        expData.push_back(32'h1234_5678);
        // R15 as the stored register reads as its own address plus 8
        storeExpect(15, 'h248, progIdx * 4 + 8);
        finishProgram();
        applyReset();
        runProgram();
        compareStores("load and store");
    endtask

    task automatic conditionTest();
        logic [31:0] big;
        startProgram();
        big = rotImm('hFF, 4);
        emit(dpImm(AL, CMD_ADD, 0, 1, 0, 0, 5));
        emit(dpImm(AL, CMD_ADD, 0, 2, 0, 0, 5));
        emit(dpImm(AL, CMD_ADD, 0, 3, 0, 0, 9));
        // Equal operands set Z
        emit(dpReg(AL, CMD_CMP, 1, 0, 1, 2));
        condStore(EQ, 1, 'h100, 32'd5, 1'b1);
        condStore(NE, 3, 'h104, 32'd9, 1'b0);
        // 5 against 9 gives a negative result with a borrow
        emit(dpReg(AL, CMD_CMP, 1, 0, 1, 3));
        condStore(LT, 1, 'h108, 32'd5, 1'b1);
        condStore(CC, 3, 'h10C, 32'd9, 1'b1);
        condStore(GE, 2, 'h110, 32'd5, 1'b0);
        // Doubling 0xFF000000 carries out of bit 31
        emit(dpImm(AL, CMD_ADD, 0, 4, 0, 4, 'hFF));
        emit(dpReg(AL, CMD_ADD, 1, 5, 4, 4));
        condStore(CS, 5, 'h114, big + big, 1'b1);
        condStore(CC, 5, 'h118, big + big, 1'b0);
        // Z is clear here, so the ADDEQ must leave R6 alone
        emit(dpImm(AL, CMD_ADD, 0, 6, 0, 0, 3));
        emit(dpImm(EQ, CMD_ADD, 0, 6, 0, 0, 7));
        storeExpect(6, 'h11C, 32'd3);
        // SUBSNE passes on the old flags and must write R7 although its result sets Z
        emit(dpImm(AL, CMD_ADD, 0, 7, 0, 0, 1));
        emit(dpImm(NE, CMD_SUB, 1, 7, 7, 0, 1));
        storeExpect(7, 'h120, 32'd0);
        finishProgram();
        applyReset();
        runProgram();
        compareStores("conditional execution");
    endtask

    task automatic branchTest();
        int loopTop;
        int i;
        startProgram();
        // Offset 0 lands two words on and skips the store below it
        emit(branch(AL, 0));
        emit(memOp(AL, 0, 0, 0, 'h300));
        emit(dpImm(AL, CMD_ADD, 0, 1, 0, 0, LOOP_COUNT));
        emit(dpImm(AL, CMD_ADD, 0, 2, 0, 12, 'h01));
        // Count down and store the counter at consecutive words from 0x100
        loopTop = progIdx;
        emit(memOp(AL, 0, 1, 2, 0));
        emit(dpImm(AL, CMD_ADD, 0, 2, 2, 0, 4));
        emit(dpImm(AL, CMD_SUB, 1, 1, 1, 0, 1));
        emit(branch(NE, loopTop - progIdx - 2));
        for (i = 0; i < LOOP_COUNT; i++) begin
            expAddr.push_back(32'h100 + 4 * i);
            expData.push_back(LOOP_COUNT - i);
        end
        // The loop leaves Z set so this BNE falls through to the store
        emit(branch(NE, 0));
        storeExpect(1, 'h140, 32'd0);
        finishProgram();
        applyReset();
        runProgram();
        compareStores("branches");
    endtask

    task automatic randomOperandTest();
        logic [31:0] a;
        logic [31:0] b;
        startProgram();
        a = $urandom;
        b = $urandom;
        image['h90] = a;
        image['h91] = b;
        emit(memOp(AL, 1, 1, 0, 'h240));
        emit(memOp(AL, 1, 2, 0, 'h244));
        emit(dpReg(AL, CMD_ADD, 0, 3, 1, 2));
        emit(dpReg(AL, CMD_SUB, 0, 4, 1, 2));
        storeExpect(3, 'h280, a + b);
        storeExpect(4, 'h284, a - b);
        finishProgram();
        applyReset();
        runProgram();
        compareStores("random operands");
    endtask

    // -------------------------------------------------------------------------
    // Test sequence
    // -------------------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        dataProcessingTest();
        loadStoreTest();
        conditionTest();
        branchTest();
        randomOperandTest();
        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
